/* project.f */
rtl/afferent_pkg.sv
rtl/host_regs_pkg.sv
rtl/axil_param_regs.sv
rtl/axil_status_read.sv
rtl/tick_gen.sv
rtl/wave_buffer.sv
rtl/afferent_channel.sv
rtl/spindle_rack_top.sv
sim/tb_clk_gen.sv
sim/spindle_rack_tb.sv

/* rtl/afferent_channel.sv */
`timescale 1ns/1ns

module afferent_channel #(
    parameter int THRESHOLD = 30720
) (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  sim_reset,
    input  afferent_pkg::rate_t   stim_in,
    input  afferent_pkg::rate_t   offset,
    input  afferent_pkg::gain_t   gain,
    input  logic                  neuron_tick,
    input  logic                  sim_tick,
    output logic                  spike,
    output afferent_pkg::count_t  count
);
    import afferent_pkg::*;

    localparam potential_t THRESH = potential_t'(THRESHOLD);

    rate_t       above;          // stimulus above offset, floored at zero
    logic [47:0] product;        // 32 x 16 before the fraction shift
    current_t    current;
    potential_t  acc;            // membrane accumulator
    logic [32:0] acc_sum;        // one extra bit to catch overflow
    potential_t  acc_next;
    count_t      run_cnt;        // spikes so far in this window

    // offset removal and gain, one register stage
    assign above   = (stim_in > offset) ? stim_in - offset : '0;
    assign product = above * gain;

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            current <= '0;
        end else begin
            current <= current_t'(product >> GAIN_FRAC);  // top bits past 32 dropped
        end
    end

    // integrate and fire
    assign acc_sum  = {1'b0, acc} + {1'b0, current};
    assign acc_next = acc_sum[32] ? '1 : acc_sum[31:0];   // saturate
    assign spike    = neuron_tick && (acc_next >= THRESH);

    always_ff @(posedge ep50trig) begin
        if (reset_global || sim_reset) begin
            acc <= '0;
        end else if (neuron_tick) begin
            acc <= spike ? acc_next - THRESH : acc_next;
        end
    end

    // windowed counter, a spike on the window tick opens the new window
    always_ff @(posedge ep50trig) begin
        if (reset_global || sim_reset) begin
            run_cnt <= '0;
            count   <= '0;
        end else if (sim_tick) begin
            count   <= run_cnt;
            run_cnt <= spike ? count_t'(1) : '0;
        end else if (spike) begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    a_spike_on_tick : assert property (@(posedge ep50trig) disable iff (reset_global)
        spike |-> neuron_tick);

endmodule

/* rtl/afferent_pkg.sv */
package afferent_pkg;

    // gain registers are unsigned 8.8 fixed point, 256 means 1.0
    localparam int GAIN_FRAC = 8;

    typedef logic [31:0] rate_t;        // stimulus or afferent rate, unsigned
    typedef logic [15:0] gain_t;        // unsigned gain, GAIN_FRAC fraction bits
    typedef logic [31:0] current_t;     // neuron input after offset and gain
    typedef logic [31:0] count_t;       // spikes per window
    typedef logic [31:0] potential_t;   // membrane accumulator, integer units

endpackage

/* rtl/axil_param_regs.sv */
`timescale 1ns/1ns

module axil_param_regs (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  awvalid,
    output logic                  awready,
    input  host_regs_pkg::addr_t  awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  host_regs_pkg::data_t  wdata,
    output logic                  bvalid,
    input  logic                  bready,
    output host_regs_pkg::resp_t  bresp,
    output logic                  ctrl_sim_reset,
    output logic                  ctrl_use_buffer,
    output logic                  ctrl_wave_clear,
    output afferent_pkg::rate_t   stim,
    output afferent_pkg::rate_t   ia_offset,
    output afferent_pkg::rate_t   ii_offset,
    output afferent_pkg::gain_t   ia_gain,
    output afferent_pkg::gain_t   ii_gain,
    output host_regs_pkg::data_t  tick_period,
    output logic                  wave_wr,
    output afferent_pkg::rate_t   wave_wdata
);
    import host_regs_pkg::*;
    import afferent_pkg::*;

    logic wr_en;      // address and data accepted this cycle
    logic addr_ok;    // writable address

    assign wr_en = awready & wready & awvalid & wvalid;

    always_comb begin
        case (awaddr)
            ADDR_CTRL, ADDR_STIM, ADDR_IA_OFFSET, ADDR_IA_GAIN,
            ADDR_II_OFFSET, ADDR_II_GAIN, ADDR_TICK_PERIOD, ADDR_WAVE_DATA: addr_ok = 1'b1;
            default: addr_ok = 1'b0;    // read-only or unmapped
        endcase
    end

    // one-cycle ready pulse, no new accept while a response is pending
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid & wvalid & ~bvalid & ~awready;
            wready  <= awvalid & wvalid & ~bvalid & ~awready;
            if (wr_en) begin
                bvalid <= 1'b1;
                bresp  <= addr_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;                 // response taken
            end
        end
    end

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            ctrl_sim_reset  <= 1'b0;
            ctrl_use_buffer <= 1'b0;            // stimulus register by default
            ctrl_wave_clear <= 1'b0;
            stim            <= DEF_STIM;
            ia_offset       <= DEF_OFFSET;
            ii_offset       <= DEF_OFFSET;
            ia_gain         <= gain_t'(DEF_IA_GAIN);
            ii_gain         <= gain_t'(DEF_II_GAIN);
            tick_period     <= DEF_TICK_PERIOD;
        end else if (wr_en) begin
            case (awaddr)
                ADDR_CTRL: begin
                    ctrl_sim_reset  <= wdata[0];
                    ctrl_use_buffer <= wdata[1];
                    ctrl_wave_clear <= wdata[2];
                end
                ADDR_STIM:        stim        <= wdata;
                ADDR_IA_OFFSET:   ia_offset   <= wdata;
                ADDR_IA_GAIN:     ia_gain     <= gain_t'(wdata);  // upper half dropped
                ADDR_II_OFFSET:   ii_offset   <= wdata;
                ADDR_II_GAIN:     ii_gain     <= gain_t'(wdata);
                ADDR_TICK_PERIOD: tick_period <= wdata;
                default: ;
            endcase
        end
    end

    // sample append strobe for the wave buffer
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            wave_wr <= 1'b0;
        end else begin
            wave_wr <= wr_en && (awaddr == ADDR_WAVE_DATA);
        end
        wave_wdata <= wdata;
    end

    a_bvalid_hold : assert property (@(posedge ep50trig) disable iff (reset_global)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

/* rtl/axil_status_read.sv */
`timescale 1ns/1ns

module axil_status_read (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  arvalid,
    output logic                  arready,
    input  host_regs_pkg::addr_t  araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output host_regs_pkg::data_t  rdata,
    output host_regs_pkg::resp_t  rresp,
    input  afferent_pkg::rate_t   stim,
    input  afferent_pkg::rate_t   ia_offset,
    input  afferent_pkg::gain_t   ia_gain,
    input  afferent_pkg::rate_t   ii_offset,
    input  afferent_pkg::gain_t   ii_gain,
    input  host_regs_pkg::data_t  tick_period,
    input  logic                  ctrl_sim_reset,
    input  logic                  ctrl_use_buffer,
    input  logic                  ctrl_wave_clear,
    input  afferent_pkg::count_t  ia_count,
    input  afferent_pkg::count_t  ii_count,
    input  afferent_pkg::rate_t   wave_sample
);
    import host_regs_pkg::*;

    data_t rd_mux;    // readback word for araddr
    logic  rd_err;    // write-only or unmapped
    logic  rd_en;

    assign rd_en = arready & arvalid;

    always_comb begin
        rd_err = 1'b0;
        case (araddr)
            ADDR_CTRL:        rd_mux = {29'd0, ctrl_wave_clear, ctrl_use_buffer, ctrl_sim_reset};
            ADDR_STIM:        rd_mux = stim;
            ADDR_IA_OFFSET:   rd_mux = ia_offset;
            ADDR_IA_GAIN:     rd_mux = {16'd0, ia_gain};
            ADDR_II_OFFSET:   rd_mux = ii_offset;
            ADDR_II_GAIN:     rd_mux = {16'd0, ii_gain};
            ADDR_TICK_PERIOD: rd_mux = tick_period;
            ADDR_IA_COUNT:    rd_mux = ia_count;
            ADDR_II_COUNT:    rd_mux = ii_count;
            ADDR_WAVE_SAMPLE: rd_mux = wave_sample;
            default: begin
                rd_mux = '0;                // includes ADDR_WAVE_DATA
                rd_err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid & ~rvalid & ~arready;    // single-cycle accept
            if (rd_en) begin
                rvalid <= 1'b1;
                rdata  <= rd_mux;                       // captured, held until rready
                rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    a_rdata_hold : assert property (@(posedge ep50trig) disable iff (reset_global)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* rtl/host_regs_pkg.sv */
package host_regs_pkg;

    typedef logic [7:0]  addr_t;        // axi byte address
    typedef logic [31:0] data_t;        // axi data word
    typedef logic [1:0]  resp_t;        // bresp / rresp

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // register map, byte addresses
    localparam addr_t ADDR_CTRL        = 8'h00;  // bit0 sim_reset, bit1 use_buffer, bit2 wave_clear
    localparam addr_t ADDR_STIM        = 8'h04;
    localparam addr_t ADDR_IA_OFFSET   = 8'h08;
    localparam addr_t ADDR_IA_GAIN     = 8'h0C;
    localparam addr_t ADDR_II_OFFSET   = 8'h10;
    localparam addr_t ADDR_II_GAIN     = 8'h14;
    localparam addr_t ADDR_TICK_PERIOD = 8'h18;
    localparam addr_t ADDR_WAVE_DATA   = 8'h20;  // write only, appends one sample
    localparam addr_t ADDR_IA_COUNT    = 8'h30;  // read only
    localparam addr_t ADDR_II_COUNT    = 8'h34;  // read only
    localparam addr_t ADDR_WAVE_SAMPLE = 8'h38;  // read only, stimulus now in use

    // power-up values of the parameter registers
    localparam data_t DEF_STIM        = 32'd1;
    localparam data_t DEF_OFFSET      = 32'd10;   // both channels
    localparam data_t DEF_IA_GAIN     = 32'd307;  // ~1.2 in 8.8
    localparam data_t DEF_II_GAIN     = 32'd512;  // 2.0 in 8.8
    localparam data_t DEF_TICK_PERIOD = 32'd381;  // half real-time speed on the rack

endpackage

/* rtl/spindle_rack_top.sv */
`timescale 1ns/1ns

module spindle_rack_top #(
    parameter int NEURON_PER_SIM = 128,
    parameter int WAVE_DEPTH     = 2048,
    parameter int THRESHOLD      = 30720
) (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  awvalid,
    output logic                  awready,
    input  host_regs_pkg::addr_t  awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  host_regs_pkg::data_t  wdata,
    output logic                  bvalid,
    input  logic                  bready,
    output host_regs_pkg::resp_t  bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  host_regs_pkg::addr_t  araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output host_regs_pkg::data_t  rdata,
    output host_regs_pkg::resp_t  rresp,
    output logic                  spike_ia,
    output logic                  spike_ii
);
    import afferent_pkg::*;
    import host_regs_pkg::*;

    logic   ctrl_sim_reset, ctrl_use_buffer, ctrl_wave_clear;
    rate_t  stim, ia_offset, ii_offset;
    gain_t  ia_gain, ii_gain;
    data_t  tick_period;
    logic   wave_wr;
    rate_t  wave_wdata;
    rate_t  wave_sample;                 // stimulus fed to both channels
    logic   neuron_tick, sim_tick;
    count_t ia_count, ii_count;

    axil_param_regs i_regs (
        .ep50trig, .reset_global,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
        .ctrl_sim_reset, .ctrl_use_buffer, .ctrl_wave_clear,
        .stim, .ia_offset, .ii_offset, .ia_gain, .ii_gain, .tick_period,
        .wave_wr, .wave_wdata
    );

    wave_buffer #(.WAVE_DEPTH(WAVE_DEPTH)) i_wave (
        .ep50trig, .reset_global, .sim_reset(ctrl_sim_reset),
        .wave_clear(ctrl_wave_clear), .use_buffer(ctrl_use_buffer),
        .wave_wr, .wave_wdata, .stim, .sim_tick, .wave_sample
    );

    tick_gen #(.NEURON_PER_SIM(NEURON_PER_SIM)) i_ticks (
        .ep50trig, .reset_global, .sim_reset(ctrl_sim_reset),
        .tick_period, .neuron_tick, .sim_tick
    );

    afferent_channel #(.THRESHOLD(THRESHOLD)) i_ia (
        .ep50trig, .reset_global, .sim_reset(ctrl_sim_reset), .stim_in(wave_sample),
        .offset(ia_offset), .gain(ia_gain), .neuron_tick, .sim_tick,
        .spike(spike_ia), .count(ia_count)
    );

    afferent_channel #(.THRESHOLD(THRESHOLD)) i_ii (
        .ep50trig, .reset_global, .sim_reset(ctrl_sim_reset), .stim_in(wave_sample),
        .offset(ii_offset), .gain(ii_gain), .neuron_tick, .sim_tick,
        .spike(spike_ii), .count(ii_count)
    );

    axil_status_read i_status (
        .ep50trig, .reset_global,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .stim, .ia_offset, .ia_gain, .ii_offset, .ii_gain, .tick_period,
        .ctrl_sim_reset, .ctrl_use_buffer, .ctrl_wave_clear,
        .ia_count, .ii_count, .wave_sample
    );

endmodule

/* rtl/tick_gen.sv */
`timescale 1ns/1ns

module tick_gen #(
    parameter int NEURON_PER_SIM = 128
) (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  sim_reset,
    input  host_regs_pkg::data_t  tick_period,
    output logic                  neuron_tick,
    output logic                  sim_tick
);
    import host_regs_pkg::*;

    localparam int SW = $clog2(NEURON_PER_SIM + 1);

    data_t         div_cnt;       // cycles since last neuron tick
    data_t         period_m1;     // terminal count where a zero period acts as one
    logic [SW-1:0] sim_cnt;       // neuron ticks in the current window
    logic          div_wrap;

    assign period_m1 = (tick_period == '0) ? '0 : tick_period - 1'b1;
    assign div_wrap  = (div_cnt >= period_m1);  // also catches a period cut short by the host

    always_ff @(posedge ep50trig) begin
        if (reset_global || sim_reset) begin
            div_cnt     <= '0;
            sim_cnt     <= '0;
            neuron_tick <= 1'b0;
            sim_tick    <= 1'b0;
        end else begin
            neuron_tick <= div_wrap;
            sim_tick    <= 1'b0;
            if (div_wrap) begin
                div_cnt <= '0;
                if (sim_cnt == SW'(NEURON_PER_SIM - 1)) begin
                    sim_cnt  <= '0;
                    sim_tick <= 1'b1;           // lands with the last neuron tick
                end else begin
                    sim_cnt <= sim_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    a_sim_on_neuron : assert property (@(posedge ep50trig) disable iff (reset_global)
        sim_tick |-> neuron_tick);

endmodule

/* rtl/wave_buffer.sv */
`timescale 1ns/1ns

module wave_buffer #(
    parameter int WAVE_DEPTH = 2048
) (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic                 sim_reset,
    input  logic                 wave_clear,
    input  logic                 use_buffer,
    input  logic                 wave_wr,
    input  afferent_pkg::rate_t  wave_wdata,
    input  afferent_pkg::rate_t  stim,
    input  logic                 sim_tick,
    output afferent_pkg::rate_t  wave_sample
);
    import afferent_pkg::*;

    localparam int AW = $clog2(WAVE_DEPTH);
    localparam int CW = AW + 1;          // holds 0..WAVE_DEPTH

    rate_t         mem [WAVE_DEPTH];
    logic [CW-1:0] wr_cnt;               // samples written, also the write pointer
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] rd_next;
    logic [AW-1:0] rd_idx;               // rd_ptr held inside the written range

    assign rd_next = {1'b0, rd_ptr} + 1'b1;
    assign rd_idx  = ({1'b0, rd_ptr} < wr_cnt) ? rd_ptr : '0;

    // host side, appends stop at WAVE_DEPTH
    always_ff @(posedge ep50trig) begin
        if (reset_global || wave_clear) begin
            wr_cnt <= '0;
        end else if (wave_wr && (wr_cnt < CW'(WAVE_DEPTH))) begin
            mem[wr_cnt[AW-1:0]] <= wave_wdata;
            wr_cnt              <= wr_cnt + 1'b1;
        end
    end

    // playback, one sample per window
    always_ff @(posedge ep50trig) begin
        if (reset_global || sim_reset) begin
            rd_ptr <= '0;
        end else if (sim_tick) begin
            rd_ptr <= (rd_next >= wr_cnt) ? '0 : rd_next[AW-1:0];   // wrap at written count
        end
    end

    // registered output, follows the pointer by one cycle
    always_ff @(posedge ep50trig) begin
        if (!use_buffer) begin
            wave_sample <= stim;
        end else if (wr_cnt == '0) begin
            wave_sample <= '0;                  // empty buffer
        end else begin
            wave_sample <= mem[rd_idx];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module spindle_rack_tb -o sim_rack
./obj_dir/sim_rack | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* sim/rack_stim.txt */
# test op addr data expect, addr data expect in hex
# w/l write data or <data> random bits (expect bresp), r/e read (expect rdata), k read back <data> regs, t/q wait <data> windows (q expects spike count)
1 r 00 0 0
1 r 04 0 1
1 r 08 0 a
1 r 0c 0 133
1 r 10 0 a
1 r 14 0 200
1 r 18 0 17d
1 r 30 0 0
1 r 34 0 0
1 q 00 1 0
2 l 00 3 0
2 l 04 20 0
2 l 08 20 0
2 l 0c 10 0
2 l 10 20 0
2 l 14 10 0
2 l 18 20 0
2 k 00 7 0
2 w 30 5a 2
2 w 38 5a 2
2 w 24 5a 2
2 e 20 0 0
2 e 3c 0 0
2 k 00 7 0
3 w 18 4 0
3 w 08 a 0
3 w 0c 100 0
3 w 10 a 0
3 w 14 200 0
3 w 04 1e0a 0
3 w 00 1 0
3 w 00 0 0
3 t 00 2 0
3 r 30 0 2
3 r 34 0 4
4 w 04 a 0
4 w 00 1 0
4 w 00 0 0
4 q 00 3 0
4 r 30 0 0
4 r 34 0 0
5 w 00 4 0
5 w 00 0 0
5 w 20 3 0
5 w 20 5 0
5 w 20 7 0
5 w 20 9 0
5 w 00 3 0
5 w 00 2 0
5 r 38 0 3
5 t 00 1 0
5 r 38 0 5
5 t 00 1 0
5 r 38 0 7
5 t 00 1 0
5 r 38 0 9
5 t 00 1 0
5 r 38 0 3
6 w 04 1e0a 0
6 w 00 1 0
6 w 00 0 0
6 t 00 2 0
6 r 30 0 2
6 r 34 0 4
6 w 00 1 0
6 r 30 0 0
6 r 34 0 0
6 w 00 0 0
6 r 30 0 0
6 r 34 0 0
6 k 00 7 0

/* sim/spindle_rack_tb.sv */
`timescale 1ns/1ns

module spindle_rack_tb;
    import host_regs_pkg::*;

    localparam int    NEURON_PER_SIM = 8;
    localparam int    WAVE_DEPTH     = 16;
    localparam int    RESET_CYCLES   = 16;
    localparam int    OP_CYCLES      = 8;       // generous bound for one axi transfer
    localparam string STIM_FILE      = "sim/rack_stim.txt";

    logic  ep50trig, reset_global;
    logic  awvalid, awready, wvalid, wready, bvalid, bready;
    logic  arvalid, arready, rvalid, rready;
    addr_t awaddr, araddr;
    data_t wdata, rdata;
    resp_t bresp, rresp;
    logic  spike_ia, spike_ii;

    // vectors, one entry per stimulus line
    int    vec_test[$];
    string vec_op[$];
    data_t vec_addr[$];
    data_t vec_data[$];
    data_t vec_exp[$];

    data_t       shadow [256];                  // last value accepted per register
    logic [15:0] lfsr        = 16'd88;
    int          cycles      = 0;
    int          cycle_limit = 0;               // zero until the vectors are loaded
    int          checks      = 0;
    int          errors      = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) i_clk (.ep50trig, .reset_global);

    spindle_rack_top #(
        .NEURON_PER_SIM(NEURON_PER_SIM),
        .WAVE_DEPTH(WAVE_DEPTH)
    ) i_dut (.*);

    // watchdog
    always @(posedge ep50trig) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: DUT gave no response within %0d cycles, run stopped", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output data_t v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);             // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input data_t got, input data_t exp, input string what);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic axi_write(input addr_t addr, input data_t data, output resp_t resp);
        @(negedge ep50trig);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge ep50trig); while (!awready);   // accept lands on the next rise
        @(negedge ep50trig);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge ep50trig);
        resp = bresp;
    endtask

    task automatic axi_read(input addr_t addr, output data_t data, output resp_t resp);
        @(negedge ep50trig);
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge ep50trig); while (!arready);
        @(negedge ep50trig);
        arvalid = 1'b0;
        while (!rvalid) @(negedge ep50trig);
        data = rdata;
        resp = rresp;
    endtask

    // counts spike pulses on both outputs until n window ticks have passed
    task automatic wait_windows(input int n, output int spikes);
        int seen;
        seen   = 0;
        spikes = 0;
        while (seen < n) begin
            @(negedge ep50trig);
            spikes += int'(spike_ia) + int'(spike_ii);
            if (i_dut.sim_tick) seen++;
        end
    endtask

    task automatic load_vectors();
        int     fd, n, t, ops;
        string  line, op;
        data_t  a, d, e, period;
        longint win_cycles;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            errors++;
            return;
        end
        period     = DEF_TICK_PERIOD;
        win_cycles = 0;
        ops        = 0;
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %s %h %h %h", t, op, a, d, e);
                if (n == 5) begin
                    vec_test.push_back(t);
                    vec_op.push_back(op);
                    vec_addr.push_back(a);
                    vec_data.push_back(d);
                    vec_exp.push_back(e);
                    if (op == "t" || op == "q")
                        win_cycles += longint'(d) * longint'(period) * NEURON_PER_SIM;
                    else
                        ops += (op == "k") ? int'(d) : 1;
                    if (op == "w" && a == data_t'(ADDR_TICK_PERIOD))
                        period = (d == '0) ? 32'd1 : d;     // zero period runs as one
                end
            end
        end
        $fclose(fd);
        cycle_limit = int'((RESET_CYCLES + win_cycles + longint'(ops) * OP_CYCLES) * 3 / 2);
    endtask

    task automatic run_vector(input int i);
        string op;
        addr_t a, ka;
        data_t d, e, got;
        resp_t resp;
        int    spikes, k;
        op = vec_op[i];
        a  = addr_t'(vec_addr[i]);
        d  = vec_data[i];
        e  = vec_exp[i];
        if (op == "w" || op == "l") begin
            if (op == "l") draw_bits(int'(d), d);          // data column is the bit count
            axi_write(a, d, resp);
            check_value(data_t'(resp), e, $sformatf("bresp of write to %h", a));
            if (resp == RESP_OKAY) shadow[a] = d;
        end else if (op == "r" || op == "e") begin
            axi_read(a, got, resp);
            check_value(got, e, $sformatf("read of %h", a));
            check_value(data_t'(resp), (op == "e") ? data_t'(RESP_SLVERR) : data_t'(RESP_OKAY),
                        $sformatf("rresp of %h", a));
        end else if (op == "k") begin
            for (k = 0; k < int'(d); k++) begin            // consecutive registers
                ka = a + addr_t'(4 * k);
                axi_read(ka, got, resp);
                check_value(got, shadow[ka], $sformatf("readback of %h", ka));
            end
        end else if (op == "t" || op == "q") begin
            wait_windows(int'(d), spikes);
            if (op == "q") check_value(data_t'(spikes), e, "spike pulses over the windows");
        end else begin
            $display("unknown operation %s on stimulus entry %0d", op, i + 1);
            errors++;
            test_errors++;
        end
    endtask

    initial begin
        int i, cur_test, ntests;
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        arvalid  = 1'b0;
        awaddr   = '0;
        araddr   = '0;
        wdata    = '0;
        bready   = 1'b1;                         // responses taken at once
        rready   = 1'b1;
        cur_test = -1;
        ntests   = 0;
        load_vectors();
        if (vec_test.size() == 0) begin
            $display("no test vectors were found in %s", STIM_FILE);
            errors++;
        end
        wait (reset_global === 1'b0);
        for (i = 0; i < vec_test.size(); i++) begin
            if (vec_test[i] != cur_test) begin
                if (cur_test >= 0)
                    $display("test %0d done: %0d checks, %0d failed", cur_test, test_checks,
                             test_errors);
                cur_test    = vec_test[i];
                test_checks = 0;
                test_errors = 0;
                ntests++;
            end
            run_vector(i);
        end
        if (cur_test >= 0)
            $display("test %0d done: %0d checks, %0d failed", cur_test, test_checks, test_errors);
        $display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic ep50trig,
    output logic reset_global
);
    initial begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;                    // synchronous, held from time zero
        repeat (RESET_CYCLES) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;                    // released between edges
    end

    always #(PERIOD_NS / 2) ep50trig = ~ep50trig;

endmodule
